// ==== verilog/cell_pkg.sv ====
package cell_pkg;

    localparam int DATA_W = 8;

    ////////////////////////////////////////
    // Cell operations
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_UPDATE         = 3'd0,
        OP_LOOKUP         = 3'd1,
        OP_ENCODE         = 3'd2,
        OP_CONGRUE_UP     = 3'd3,
        OP_CONGRUE_DOWN   = 3'd4,
        OP_MARK_AVAILABLE = 3'd5,
        OP_ENRANK         = 3'd6,
        OP_PROBE          = 3'd7
    } cell_op_e;

    // Broadcast to every cell
    typedef struct packed {
        logic              valid;
        cell_op_e          op;
        logic [DATA_W-1:0] index;
        logic [DATA_W-1:0] value;
        logic [DATA_W-1:0] meta;
        logic              is_meta;
    } cell_cmd_t;

    typedef struct packed {
        logic              hit;
        logic [DATA_W-1:0] result;
        logic [DATA_W-1:0] ctx;
    } cell_answer_t;

    // Lowest matching cell of the row
    typedef struct packed {
        logic              hit;
        logic [DATA_W-1:0] winner;
        logic [DATA_W-1:0] result;
        logic [DATA_W-1:0] ctx;
    } row_answer_t;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////

    localparam logic [7:0] REG_INDEX   = 8'h00;
    localparam logic [7:0] REG_VALUE   = 8'h04;
    localparam logic [7:0] REG_META    = 8'h08;
    localparam logic [7:0] REG_COMMAND = 8'h0C;
    localparam logic [7:0] REG_RESULT  = 8'h10;
    localparam logic [7:0] REG_STATUS  = 8'h14;

endpackage

// ==== verilog/memory_cell.sv ====
module memory_cell #(
    parameter int NUM_CELLS = 8,
    parameter int CELL_ID   = 0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  cell_pkg::cell_cmd_t    cmd,
    output cell_pkg::cell_answer_t answer
);
    import cell_pkg::*;

    // One array element
    typedef struct packed {
        logic              arr_def;
        logic [DATA_W-1:0] code;
        logic              elt_def;
        logic [DATA_W-1:0] rank;
        logic [DATA_W-1:0] low;
        logic [DATA_W-1:0] high;
        logic [DATA_W-1:0] index;
        logic [DATA_W-1:0] value;
    } elem_t;

    localparam logic [DATA_W-1:0] HANDLE     = DATA_W'(CELL_ID);
    localparam logic [DATA_W-1:0] CELL_LIMIT = DATA_W'(NUM_CELLS);

    elem_t        elem;
    elem_t        elem_next;
    cell_answer_t answer_next;
    logic         meta_ok;
    logic         own_sel;

    always_ff @(posedge clk) begin
        if (!reset) begin
            elem   <= '0;
            answer <= '0;
        end else if (cmd.valid) begin
            elem   <= elem_next;
            answer <= answer_next;
        end
    end

    always_comb begin
        elem_next   = elem;
        answer_next = '0;
        // Meta names a cell that exists
        meta_ok     = cmd.is_meta && (cmd.meta < CELL_LIMIT);
        own_sel     = cmd.is_meta && (cmd.index == HANDLE);

        case (cmd.op)
            OP_UPDATE: begin
                answer_next.hit = cmd.is_meta && (cmd.meta == HANDLE);
                if (answer_next.hit) begin
                    elem_next.arr_def = 1'b1;
                    elem_next.code    = HANDLE;
                    elem_next.elt_def = 1'b1;
                    elem_next.rank    = DATA_W'(1);
                    elem_next.low     = HANDLE;
                    elem_next.high    = HANDLE;
                    elem_next.index   = cmd.index;
                    elem_next.value   = cmd.value;
                end
                answer_next.result = HANDLE;
                answer_next.ctx    = HANDLE;
            end

            OP_LOOKUP: begin
                answer_next.hit    = cmd.is_meta && (elem.index == cmd.index)
                                     && (cmd.meta >= elem.low) && (cmd.meta <= elem.high);
                answer_next.result = elem.value;
                answer_next.ctx    = elem.rank;
            end

            OP_ENCODE: begin
                answer_next.hit    = meta_ok && elem.arr_def && (cmd.meta == HANDLE);
                answer_next.result = elem.code;
                answer_next.ctx    = elem.code;
            end

            OP_CONGRUE_UP: begin
                if (own_sel) begin
                    // This cell takes the inserted position
                    elem_next.code = cmd.meta + 1'b1;
                    elem_next.low  = cmd.meta + 1'b1;
                    elem_next.high = cmd.meta + 1'b1;
                    elem_next.rank = cmd.value + 1'b1;
                end else begin
                    if (cmd.is_meta && elem.arr_def && (elem.code > cmd.meta)) begin
                        elem_next.code = elem.code + 1'b1;
                    end
                    if (cmd.is_meta && elem.elt_def) begin
                        if (elem.low > cmd.meta) begin
                            elem_next.low = elem.low + 1'b1;
                        end
                        if (elem.high >= cmd.meta) begin
                            elem_next.high = elem.high + 1'b1;
                        end
                    end
                end
                answer_next.hit    = own_sel;
                answer_next.result = elem_next.code;
                answer_next.ctx    = elem_next.rank;
            end

            OP_CONGRUE_DOWN: begin
                if (own_sel) begin
                    elem_next.arr_def = 1'b0;
                    elem_next.rank    = '0;
                end
                if (cmd.is_meta && elem.elt_def) begin
                    if (cmd.meta < elem.low) begin
                        elem_next.low  = elem.low - 1'b1;
                        elem_next.high = elem.high - 1'b1;
                    end else if (cmd.meta <= elem.high) begin
                        elem_next.high = elem.high - 1'b1;
                    end
                end
                // Bounds crossed, element is gone
                if (elem_next.elt_def && (elem_next.low > elem_next.high)) begin
                    elem_next.elt_def = 1'b0;
                    elem_next.arr_def = 1'b0;
                end
                if (elem_next.arr_def && cmd.is_meta && (elem_next.code > cmd.meta)) begin
                    elem_next.code = elem_next.code - 1'b1;
                end
                answer_next.hit    = own_sel;
                answer_next.result = elem_next.code;
                answer_next.ctx    = elem_next.rank;
            end

            OP_MARK_AVAILABLE: begin
                answer_next.hit    = !elem.elt_def;
                answer_next.result = HANDLE;
                answer_next.ctx    = HANDLE;
            end

            OP_ENRANK: begin
                answer_next.hit    = meta_ok && elem.arr_def && (cmd.meta == HANDLE);
                answer_next.result = elem.rank;
                answer_next.ctx    = elem.rank;
            end

            OP_PROBE: begin
                answer_next.hit    = (cmd.meta < CELL_LIMIT) && (cmd.meta == HANDLE);
                answer_next.result = elem.high;
                answer_next.ctx    = elem.low;
            end
        endcase
    end

endmodule

// ==== verilog/cell_array.sv ====
module cell_array #(
    parameter int NUM_CELLS = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  cell_pkg::cell_cmd_t             cmd,
    output cell_pkg::row_answer_t           answer,
    output logic [cell_pkg::DATA_W-1:0]     match_count
);
    import cell_pkg::*;

    cell_answer_t      cell_answers [NUM_CELLS];
    row_answer_t       answer_next;
    logic [DATA_W-1:0] count_next;

    for (genvar i = 0; i < NUM_CELLS; i++) begin : g_cell
        memory_cell #(
            .NUM_CELLS (NUM_CELLS),
            .CELL_ID   (i)
        ) u_cell (
            .clk    (clk),
            .reset  (reset),
            .cmd    (cmd),
            .answer (cell_answers[i])
        );
    end

    // Walk downwards so the lowest hit is written last
    always_comb begin
        answer_next = '0;
        count_next  = '0;
        for (int i = NUM_CELLS - 1; i >= 0; i--) begin
            if (cell_answers[i].hit) begin
                answer_next.hit    = 1'b1;
                answer_next.winner = DATA_W'(i);
                answer_next.result = cell_answers[i].result;
                answer_next.ctx    = cell_answers[i].ctx;
                count_next         = count_next + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            answer      <= '0;
            match_count <= '0;
        end else begin
            answer      <= answer_next;
            match_count <= count_next;
        end
    end

endmodule

// ==== verilog/axil_command_port.sv ====
module axil_command_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [7:0]                  awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [31:0]                 wdata,
    output logic                        bvalid,
    input  logic                        bready,
    output logic [1:0]                  bresp,
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [7:0]                  araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    output cell_pkg::cell_cmd_t         cmd,
    input  cell_pkg::row_answer_t       answer,
    input  logic [cell_pkg::DATA_W-1:0] match_count
);
    import cell_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_CELLS,
        ST_WAIT_ROW,
        ST_RESPOND
    } state_e;

    state_e            state;
    cell_op_e          op_reg;
    logic [DATA_W-1:0] index_reg;
    logic [DATA_W-1:0] value_reg;
    logic [DATA_W-1:0] meta_reg;
    logic              is_meta_reg;
    row_answer_t       result_reg;
    logic [DATA_W-1:0] count_reg;
    logic              busy;
    logic              write_hs;
    logic              read_hs;
    logic [31:0]       read_data;

    ////////////////////////////////////////
    // Write channel and broadcast sequencing
    ////////////////////////////////////////

    // AW and W taken together, only when idle
    assign awready  = (state == ST_IDLE) && awvalid && wvalid;
    assign wready   = awready;
    assign write_hs = awvalid && awready && wvalid && wready;
    assign bvalid   = (state == ST_RESPOND);
    assign bresp    = 2'b00;
    assign busy     = state inside {ST_ISSUE, ST_WAIT_CELLS, ST_WAIT_ROW};

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (write_hs) begin
                        state <= (awaddr == REG_COMMAND) ? ST_ISSUE : ST_RESPOND;
                    end
                end
                ST_ISSUE:      state <= ST_WAIT_CELLS;
                ST_WAIT_CELLS: state <= ST_WAIT_ROW;
                ST_WAIT_ROW:   state <= ST_RESPOND;
                ST_RESPOND: begin
                    if (bready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            op_reg      <= OP_UPDATE;
            index_reg   <= '0;
            value_reg   <= '0;
            meta_reg    <= '0;
            is_meta_reg <= 1'b0;
            result_reg  <= '0;
            count_reg   <= '0;
        end else begin
            if (write_hs) begin
                case (awaddr)
                    REG_INDEX: index_reg <= wdata[DATA_W-1:0];
                    REG_VALUE: value_reg <= wdata[DATA_W-1:0];
                    REG_META: begin
                        meta_reg    <= wdata[DATA_W-1:0];
                        is_meta_reg <= wdata[DATA_W];
                    end
                    REG_COMMAND: op_reg <= cell_op_e'(wdata[2:0]);
                    default: ;
                endcase
            end
            // Row answer is settled by now
            if (state == ST_WAIT_ROW) begin
                result_reg <= answer;
                count_reg  <= match_count;
            end
        end
    end

    always_comb begin
        cmd.valid   = (state == ST_ISSUE);
        cmd.op      = op_reg;
        cmd.index   = index_reg;
        cmd.value   = value_reg;
        cmd.meta    = meta_reg;
        cmd.is_meta = is_meta_reg;
    end

    ////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////

    assign arready = arvalid && !rvalid;
    assign read_hs = arvalid && arready;
    assign rresp   = 2'b00;

    always_comb begin
        case (araddr)
            REG_INDEX:   read_data = 32'(index_reg);
            REG_VALUE:   read_data = 32'(value_reg);
            REG_META:    read_data = 32'({is_meta_reg, meta_reg});
            REG_COMMAND: read_data = 32'(op_reg);
            REG_RESULT:  read_data = 32'(result_reg);
            REG_STATUS:  read_data = {busy, {(31 - DATA_W){1'b0}}, count_reg};
            default:     read_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            rvalid <= 1'b0;
        end else if (read_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (read_hs) begin
            rdata <= read_data;
        end
    end

endmodule

// ==== verilog/array_memory_top.sv ====
module array_memory_top #(
    parameter int NUM_CELLS = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        awvalid,
    output logic        awready,
    input  logic [7:0]  awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [7:0]  araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);
    import cell_pkg::*;

    cell_cmd_t         cmd;
    row_answer_t       answer;
    logic [DATA_W-1:0] match_count;

    // Host port is the only command source
    axil_command_port u_port (.*);

    cell_array #(
        .NUM_CELLS (NUM_CELLS)
    ) u_array (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .answer      (answer),
        .match_count (match_count)
    );

endmodule

// ==== verif/array_memory_props.sv ====
module array_memory_props (
    input logic        clk,
    input logic        reset,
    input logic        awvalid,
    input logic        awready,
    input logic [7:0]  awaddr,
    input logic        wvalid,
    input logic        wready,
    input logic [31:0] wdata,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        announce,
    input logic [31:0] expected
);
    timeunit 1ns;
    timeprecision 1ps;
    import cell_pkg::*;

    int   fail_count = 0;
    logic cmd_hs;

    assign cmd_hs = awvalid && awready && wvalid && wready && (awaddr == REG_COMMAND);

    ////////////////////////////////////////
    // AXI4-Lite handshake rules
    ////////////////////////////////////////

    aw_w_hold: assert property (@(posedge clk) disable iff (!reset)
        (awvalid && !awready) |=> awvalid && wvalid && $stable(awaddr) && $stable(wdata))
        else begin
            $error("AW or W dropped or changed before ready");
            fail_count++;
        end

    b_hold: assert property (@(posedge clk) disable iff (!reset)
        (bvalid && !bready) |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    r_hold: assert property (@(posedge clk) disable iff (!reset)
        (rvalid && !rready) |=> rvalid && $stable(rdata))
        else begin
            $error("rdata changed while waiting for rready");
            fail_count++;
        end

    // No new write while a response is pending
    no_accept_pending: assert property (@(posedge clk) disable iff (!reset)
        bvalid |-> !awready)
        else begin
            $error("write accepted while bvalid pending");
            fail_count++;
        end

    // Responses are always OKAY
    okay_bresp: assert property (@(posedge clk) disable iff (!reset)
        bvalid |-> (bresp == 2'b00))
        else begin
            $error("error: bresp = %h, expected %h", bresp, 2'b00);
            fail_count++;
        end

    okay_rresp: assert property (@(posedge clk) disable iff (!reset)
        rvalid |-> (rresp == 2'b00))
        else begin
            $error("error: rresp = %h, expected %h", rresp, 2'b00);
            fail_count++;
        end

    ////////////////////////////////////////
    // Broadcast latency and announced reads
    ////////////////////////////////////////

    cmd_latency: assert property (@(posedge clk) disable iff (!reset)
        cmd_hs |=> (!bvalid && !awready) ##1 (!bvalid && !awready)
                   ##1 (!bvalid && !awready) ##1 (bvalid && !awready))
        else begin
            $error("command response not exactly four cycles after handshake");
            fail_count++;
        end

    announced_read: assert property (@(posedge clk) disable iff (!reset)
        announce |-> (rdata == expected))
        else begin
            $error("error: rdata = %h, expected %h", rdata, expected);
            fail_count++;
        end

endmodule

// ==== verif/array_memory_tb.sv ====
module array_memory_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cell_pkg::*;

    localparam int          NUM_CELLS  = 8;
    localparam int          WAIT_LIMIT = 50;
    localparam logic [31:0] SEED       = 32'h55d8_bb64;
    localparam logic [7:0]  NO_CELL    = 8'hFF;
    localparam int          CH_AW      = 0;
    localparam int          CH_B       = 1;
    localparam int          CH_AR      = 2;
    localparam int          CH_R       = 3;

    logic        clk = 1'b0;
    logic        reset;
    logic        awvalid;
    logic        awready;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [7:0]  araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    // Expected read data, seen by the bound checker
    logic        announce;
    logic [31:0] expected;

    logic [31:0] lfsr;
    logic [7:0]  rand_value;
    logic        stalled;
    int          errors;
    int          errors_before;
    int          checks;
    int          tests_run;

    array_memory_top #(.NUM_CELLS(NUM_CELLS)) UUT (.*);

    bind array_memory_top array_memory_props u_props (
        .*,
        .announce (array_memory_tb.announce),
        .expected (array_memory_tb.expected)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
        return b;
    endfunction

    function automatic logic channel_event(input int ch);
        case (ch)
            CH_AW:   return awready && wready;
            CH_B:    return bvalid;
            CH_AR:   return arready;
            default: return rvalid;
        endcase
    endfunction

    ////////////////////////////////////////
    // AXI4-Lite driver
    ////////////////////////////////////////

    // Returns 1 ns after the edge that completes the handshake
    task automatic wait_channel(input int ch, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!channel_event(ch) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!channel_event(ch)) begin
            $display("timeout: %s not seen within %0d cycles", what, WAIT_LIMIT);
            stalled = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        if (stalled) return;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        wait_channel(CH_AW, "awready");
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_channel(CH_B, "bvalid");
        bready = 1'b0;
    endtask

    // Hold keeps rready low for that many cycles after the AR handshake
    task automatic axil_read(input logic [7:0] addr, input int hold, output logic [31:0] data);
        data = '0;
        if (stalled) return;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        wait_channel(CH_AR, "arready");
        arvalid = 1'b0;
        if (hold > 0) begin
            repeat (hold) @(posedge clk);
            #1;
            rready = 1'b1;
        end
        wait_channel(CH_R, "rvalid");
        data   = rdata;
        rready = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string what,
                              input int hold = 0);
        logic [31:0] got;
        axil_read(addr, hold, got);
        if (stalled) return;
        checks++;
        assert (got === exp) else begin
            $display("error: %s = %h, expected %h", what, got, exp);
            errors++;
        end
        expected = exp;
        announce = 1'b1;
        @(posedge clk);
        #1;
        announce = 1'b0;
    endtask

    task automatic issue(input cell_op_e op, input logic [7:0] index, input logic [7:0] meta,
                         input logic is_meta, input logic [7:0] value);
        axil_write(REG_INDEX, {24'd0, index});
        axil_write(REG_VALUE, {24'd0, value});
        axil_write(REG_META, {23'd0, is_meta, meta});
        axil_write(REG_COMMAND, {29'd0, op});
    endtask

    task automatic expect_row(input logic hit, input logic [7:0] winner, input logic [7:0] result,
                              input logic [7:0] ctx, input logic [7:0] count);
        read_check(REG_RESULT, {7'd0, hit, winner, result, ctx}, "REG_RESULT");
        read_check(REG_STATUS, {24'd0, count}, "REG_STATUS");
    endtask

    // Second write is held on the bus during the broadcast and B back-pressure
    task automatic write_while_busy(input cell_op_e op, input logic [7:0] addr,
                                    input logic [31:0] data);
        if (stalled) return;
        awaddr  = REG_COMMAND;
        wdata   = {29'd0, op};
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        wait_channel(CH_AW, "awready");
        awaddr = addr;
        wdata  = data;
        wait_channel(CH_B, "bvalid");
        repeat (2) @(posedge clk);
        #1;
        bready = 1'b1;
        wait_channel(CH_B, "bvalid");
        wait_channel(CH_AW, "awready");
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_channel(CH_B, "bvalid");
        bready = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_before && !stalled) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: fail", tests_run, name);
        end
        errors_before = errors;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        lfsr          = SEED;
        stalled       = 1'b0;
        errors        = 0;
        errors_before = 0;
        checks        = 0;
        tests_run     = 0;
        reset         = 1'b0;
        awvalid       = 1'b0;
        awaddr        = '0;
        wvalid        = 1'b0;
        wdata         = '0;
        bready        = 1'b0;
        arvalid       = 1'b0;
        araddr        = '0;
        rready        = 1'b0;
        announce      = 1'b0;
        expected      = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;

        // Every cell free after reset
        issue(OP_MARK_AVAILABLE, 8'd0, 8'd0, 1'b0, 8'd0);
        expect_row(1'b1, 8'd0, 8'd0, 8'd0, 8'(NUM_CELLS));
        issue(OP_PROBE, 8'd0, 8'd3, 1'b1, 8'd0);
        expect_row(1'b1, 8'd3, 8'd0, 8'd0, 8'd1);
        end_test("reset state");

        rand_value = random_byte();
        issue(OP_UPDATE, 8'd5, 8'd2, 1'b1, rand_value);
        expect_row(1'b1, 8'd2, 8'd2, 8'd2, 8'd1);
        issue(OP_LOOKUP, 8'd5, 8'd2, 1'b1, 8'd0);
        expect_row(1'b1, 8'd2, rand_value, 8'd1, 8'd1);
        issue(OP_MARK_AVAILABLE, 8'd5, 8'd0, 1'b0, 8'd0);
        expect_row(1'b1, 8'd0, 8'd0, 8'd0, 8'(NUM_CELLS - 1));
        end_test("update and look-up");

        issue(OP_ENCODE, 8'd5, 8'd2, 1'b1, 8'd0);
        expect_row(1'b1, 8'd2, 8'd2, 8'd2, 8'd1);
        issue(OP_ENRANK, 8'd5, 8'd2, 1'b1, 8'd0);
        expect_row(1'b1, 8'd2, 8'd1, 8'd1, 8'd1);
        issue(OP_ENCODE, 8'd5, 8'(NUM_CELLS), 1'b1, 8'd0);
        expect_row(1'b0, 8'd0, 8'd0, 8'd0, 8'd0);
        end_test("encode and enrank");

        // Insert after position 1, no cell takes the new slot
        issue(OP_CONGRUE_UP, NO_CELL, 8'd1, 1'b1, 8'd0);
        expect_row(1'b0, 8'd0, 8'd0, 8'd0, 8'd0);
        issue(OP_PROBE, 8'd0, 8'd2, 1'b1, 8'd0);
        expect_row(1'b1, 8'd2, 8'd3, 8'd3, 8'd1);
        issue(OP_LOOKUP, 8'd5, 8'd3, 1'b1, 8'd0);
        expect_row(1'b1, 8'd2, rand_value, 8'd1, 8'd1);
        end_test("congrue up");

        issue(OP_CONGRUE_DOWN, NO_CELL, 8'd3, 1'b1, 8'd0);
        expect_row(1'b0, 8'd0, 8'd0, 8'd0, 8'd0);
        issue(OP_MARK_AVAILABLE, 8'd0, 8'd0, 1'b0, 8'd0);
        expect_row(1'b1, 8'd0, 8'd0, 8'd0, 8'(NUM_CELLS));
        end_test("congrue down");

        write_while_busy(OP_MARK_AVAILABLE, REG_INDEX, 32'h0000_005A);
        expect_row(1'b1, 8'd0, 8'd0, 8'd0, 8'(NUM_CELLS));
        read_check(REG_INDEX, 32'h0000_005A, "REG_INDEX", 3);
        end_test("write while busy");

        // Let pending latency checks complete
        repeat (6) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, checks, errors, UUT.u_props.fail_count);
        if (errors == 0 && !stalled && UUT.u_props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/cell_pkg.sv
verilog/memory_cell.sv
verilog/cell_array.sv
verilog/axil_command_port.sv
verilog/array_memory_top.sv
verif/array_memory_props.sv
verif/array_memory_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --assert -j 0 --top-module array_memory_tb -f sources.f \
    -o array_memory_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/array_memory_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
